// File: rtl/csr_pkg.sv
// ======================================================================
// CSR package
// Shared widths, CSR address map, privilege encodings, mstatus field
// positions and the decoded write-enable bundle of the CSR unit
// ======================================================================
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_word_t;

    // Address split as in the privileged spec
    typedef struct packed {
        logic [1:0] access;
        logic [1:0] priv;
        logic [7:0] index;
    } csr_addr_t;

    // Access mode 3 marks a read-only CSR
    localparam logic [1:0] ACCESS_RO = 2'b11;

    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

    // ==================================================================
    // Address map
    // ==================================================================
    localparam csr_addr_t ADDR_MSTATUS       = 12'h300;
    localparam csr_addr_t ADDR_MTVEC         = 12'h305;
    localparam csr_addr_t ADDR_MCOUNTINHIBIT = 12'h320;
    localparam csr_addr_t ADDR_MSCRATCH      = 12'h340;
    localparam csr_addr_t ADDR_MEPC          = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE        = 12'h342;
    localparam csr_addr_t ADDR_MCYCLE        = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET      = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH       = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH     = 12'hB82;
    // User shadows, read only
    localparam csr_addr_t ADDR_CYCLE         = 12'hC00;
    localparam csr_addr_t ADDR_INSTRET       = 12'hC02;
    localparam csr_addr_t ADDR_CYCLEH        = 12'hC80;
    localparam csr_addr_t ADDR_INSTRETH      = 12'hC82;

    // mstatus fields, MPP is two bits wide
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO   = 11;

    // mcountinhibit fields
    localparam int INHIBIT_CY_BIT = 0;
    localparam int INHIBIT_IR_BIT = 2;

    typedef enum logic [1:0] {
        DIRECT   = 2'd0,
        VECTORED = 2'd1
    } mtvec_mode_e;

    localparam logic [30:0] MCAUSE_RESET_CODE = 31'd0;

    typedef enum logic [3:0] {
        SEL_NONE, SEL_MSTATUS, SEL_MTVEC, SEL_INHIBIT, SEL_MSCRATCH, SEL_MEPC,
        SEL_MCAUSE, SEL_CY_LO, SEL_CY_HI, SEL_IR_LO, SEL_IR_HI
    } csr_sel_e;

    // One enable per writable register, at most one set
    typedef struct packed {
        logic mstatus;
        logic mtvec;
        logic inhibit;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic cy_lo;
        logic cy_hi;
        logic ir_lo;
        logic ir_hi;
    } csr_wen_t;

endpackage : csr_pkg

`default_nettype wire

// File: rtl/csr_addr_decode.sv
// ======================================================================
// CSR address decoder
// Maps a 12-bit CSR address onto a read selection and one-hot write
// enables, and raises the three illegal-access flags
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_addr_decode (
    input  wire logic                csr_access_i,
    input  wire logic                csr_write_i,
    input  wire csr_pkg::csr_addr_t  csr_addr_i,
    input  wire csr_pkg::priv_e      privilege_i,
    output csr_pkg::csr_sel_e        sel_o,
    output csr_pkg::csr_wen_t        wen_o,
    output logic                     illegal_privilege_o,
    output logic                     illegal_instruction_o,
    output logic                     illegal_csr_access_o
);

    csr_pkg::csr_sel_e sel;
    logic              known;
    logic              wr_ok;

    // ==================================================================
    // Address lookup
    // ==================================================================
    always_comb begin
        sel   = csr_pkg::SEL_NONE;
        known = 1'b1;
        case (csr_addr_i)
            csr_pkg::ADDR_MSTATUS:       sel = csr_pkg::SEL_MSTATUS;
            csr_pkg::ADDR_MTVEC:         sel = csr_pkg::SEL_MTVEC;
            csr_pkg::ADDR_MCOUNTINHIBIT: sel = csr_pkg::SEL_INHIBIT;
            csr_pkg::ADDR_MSCRATCH:      sel = csr_pkg::SEL_MSCRATCH;
            csr_pkg::ADDR_MEPC:          sel = csr_pkg::SEL_MEPC;
            csr_pkg::ADDR_MCAUSE:        sel = csr_pkg::SEL_MCAUSE;
            // Machine counters and their user shadows share a selection
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_CYCLE:         sel = csr_pkg::SEL_CY_LO;
            csr_pkg::ADDR_MCYCLEH,
            csr_pkg::ADDR_CYCLEH:        sel = csr_pkg::SEL_CY_HI;
            csr_pkg::ADDR_MINSTRET,
            csr_pkg::ADDR_INSTRET:       sel = csr_pkg::SEL_IR_LO;
            csr_pkg::ADDR_MINSTRETH,
            csr_pkg::ADDR_INSTRETH:      sel = csr_pkg::SEL_IR_HI;
            default:                     known = 1'b0;
        endcase
    end

    assign sel_o = sel;

    // ==================================================================
    // Illegal-access flags
    // ==================================================================
    // Address needs more privilege than the hart holds
    assign illegal_privilege_o   = csr_access_i & (csr_addr_i.priv > privilege_i);

    // Write to a read-only address
    assign illegal_instruction_o = csr_access_i & csr_write_i &
                                   (csr_addr_i.access == csr_pkg::ACCESS_RO);

    assign illegal_csr_access_o  = csr_access_i & ~known;

    // A write commits only if nothing was flagged
    assign wr_ok = csr_access_i & csr_write_i & ~illegal_privilege_o &
                   ~illegal_instruction_o & ~illegal_csr_access_o;

    // ==================================================================
    // Write enables
    // ==================================================================
    always_comb begin
        wen_o = '0;
        if (wr_ok) begin
            case (sel)
                csr_pkg::SEL_MSTATUS:  wen_o.mstatus  = 1'b1;
                csr_pkg::SEL_MTVEC:    wen_o.mtvec    = 1'b1;
                csr_pkg::SEL_INHIBIT:  wen_o.inhibit  = 1'b1;
                csr_pkg::SEL_MSCRATCH: wen_o.mscratch = 1'b1;
                csr_pkg::SEL_MEPC:     wen_o.mepc     = 1'b1;
                csr_pkg::SEL_MCAUSE:   wen_o.mcause   = 1'b1;
                csr_pkg::SEL_CY_LO:    wen_o.cy_lo    = 1'b1;
                csr_pkg::SEL_CY_HI:    wen_o.cy_hi    = 1'b1;
                csr_pkg::SEL_IR_LO:    wen_o.ir_lo    = 1'b1;
                csr_pkg::SEL_IR_HI:    wen_o.ir_hi    = 1'b1;
                default:               wen_o = '0;
            endcase
        end
    end

endmodule : csr_addr_decode

`default_nettype wire

// File: rtl/csr_trap_state.sv
// ======================================================================
// CSR trap state
// Privilege level, mstatus MIE/MPIE/MPP, mepc, mcause, mtvec and
// mscratch, updated by traps, mret and CSR writes; also registers
// the trap handler address
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_trap_state (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire csr_pkg::csr_wen_t   wen_i,
    input  wire csr_pkg::data_word_t wdata_i,
    input  wire logic                interrupt_request_i,
    input  wire logic [7:0]          interrupt_vector_i,
    input  wire logic                exception_i,
    input  wire logic [4:0]          exception_vector_i,
    input  wire csr_pkg::data_word_t trap_pc_i,
    input  wire logic                mret_i,
    output csr_pkg::priv_e           privilege_o,
    output csr_pkg::data_word_t      mstatus_o,
    output csr_pkg::data_word_t      mtvec_o,
    output csr_pkg::data_word_t      mscratch_o,
    output csr_pkg::data_word_t      mepc_o,
    output csr_pkg::data_word_t      mcause_o,
    output csr_pkg::data_word_t      handler_pc_o
);

    csr_pkg::priv_e      privilege_q;
    csr_pkg::priv_e      mpp_q;
    logic                mie_q;
    logic                mpie_q;
    csr_pkg::data_word_t mtvec_q;
    csr_pkg::data_word_t mscratch_q;
    csr_pkg::data_word_t mepc_q;
    csr_pkg::data_word_t mcause_q;
    csr_pkg::data_word_t handler_pc_q;
    csr_pkg::data_word_t base;
    logic                trap;

    assign trap = interrupt_request_i | exception_i;

    // ==================================================================
    // Privilege and mstatus
    // ==================================================================
    // Trap beats mret, mret beats a CSR write
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            privilege_q <= csr_pkg::MACHINE;
            mpp_q       <= csr_pkg::MACHINE;
            mie_q       <= 1'b0;
            mpie_q      <= 1'b0;
        end else if (trap) begin
            // Enter machine mode and stack the interrupt enable
            privilege_q <= csr_pkg::MACHINE;
            mpp_q       <= privilege_q;
            mpie_q      <= mie_q;
            mie_q       <= 1'b0;
        end else if (mret_i) begin
            privilege_q <= mpp_q;
            mie_q       <= mpie_q;
            mpie_q      <= 1'b1;
            mpp_q       <= csr_pkg::USER;
        end else if (wen_i.mstatus) begin
            // Only MIE is software writable
            mie_q <= wdata_i[csr_pkg::MSTATUS_MIE_BIT];
        end
    end

    always_comb begin
        mstatus_o                                            = '0;
        mstatus_o[csr_pkg::MSTATUS_MIE_BIT]                  = mie_q;
        mstatus_o[csr_pkg::MSTATUS_MPIE_BIT]                 = mpie_q;
        mstatus_o[csr_pkg::MSTATUS_MPP_LO+1:csr_pkg::MSTATUS_MPP_LO] = mpp_q;
    end

    // ==================================================================
    // mepc and mcause
    // ==================================================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mepc_q   <= '0;
            mcause_q <= {1'b0, csr_pkg::MCAUSE_RESET_CODE};
        end else if (interrupt_request_i) begin
            mepc_q   <= {trap_pc_i[31:1], 1'b0};
            mcause_q <= {1'b1, 23'b0, interrupt_vector_i};
        end else if (exception_i) begin
            mepc_q   <= {trap_pc_i[31:1], 1'b0};
            mcause_q <= {1'b0, 26'b0, exception_vector_i};
        end else if (!mret_i) begin
            // Instructions are at least halfword aligned
            if (wen_i.mepc) mepc_q <= {wdata_i[31:1], 1'b0};
            if (wen_i.mcause) mcause_q <= wdata_i;
        end
    end

    // ==================================================================
    // mtvec, mscratch and handler address
    // ==================================================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end else begin
            if (wen_i.mtvec) mtvec_q <= wdata_i;
            if (wen_i.mscratch) mscratch_q <= wdata_i;
        end
    end

    assign base = {mtvec_q[31:2], 2'b00};

    // Vectored mode sends interrupts to base + 4 * vector
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            handler_pc_q <= '0;
        end else if ((csr_pkg::mtvec_mode_e'(mtvec_q[1:0]) == csr_pkg::VECTORED) &&
                     interrupt_request_i) begin
            handler_pc_q <= base + {22'b0, interrupt_vector_i, 2'b00};
        end else begin
            handler_pc_q <= base;
        end
    end

    assign privilege_o  = privilege_q;
    assign mtvec_o      = mtvec_q;
    assign mscratch_o   = mscratch_q;
    assign mepc_o       = mepc_q;
    assign mcause_o     = mcause_q;
    assign handler_pc_o = handler_pc_q;

endmodule : csr_trap_state

`default_nettype wire

// File: rtl/csr_counter.sv
// ======================================================================
// CSR performance counter
// Free-running counter with an inhibit input, writable by its low
// 32-bit word and by its upper bits; serves mcycle and minstret
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_counter #(
    parameter int CNT_WIDTH = 64
) (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                inc_i,
    input  wire logic                inhibit_i,
    input  wire logic                wr_lo_i,
    input  wire logic                wr_hi_i,
    input  wire csr_pkg::data_word_t wdata_i,
    output logic [CNT_WIDTH-1:0]     count_o
);

    logic [CNT_WIDTH-1:0] count_q;

    // A software write wins over the increment in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (wr_lo_i || wr_hi_i) begin
            if (wr_lo_i) begin
                count_q[31:0] <= wdata_i;
            end
            // Upper part may be narrower than a word
            if (wr_hi_i) begin
                count_q[CNT_WIDTH-1:32] <= wdata_i[CNT_WIDTH-33:0];
            end
        end else if (inc_i && !inhibit_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count_o = count_q;

endmodule : csr_counter

`default_nettype wire

// File: rtl/csr_read_mux.sv
// ======================================================================
// CSR read multiplexer
// Returns the selected CSR word and holds mcountinhibit, whose bits
// stop the cycle and instret counters
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux #(
    parameter int CNT_WIDTH = 64
) (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire csr_pkg::csr_sel_e   sel_i,
    input  wire csr_pkg::csr_wen_t   wen_i,
    input  wire csr_pkg::data_word_t wdata_i,
    input  wire csr_pkg::data_word_t mstatus_i,
    input  wire csr_pkg::data_word_t mtvec_i,
    input  wire csr_pkg::data_word_t mscratch_i,
    input  wire csr_pkg::data_word_t mepc_i,
    input  wire csr_pkg::data_word_t mcause_i,
    input  wire logic [CNT_WIDTH-1:0] cycle_i,
    input  wire logic [CNT_WIDTH-1:0] instret_i,
    output csr_pkg::data_word_t      rdata_o,
    output logic                     inhibit_cy_o,
    output logic                     inhibit_ir_o
);

    logic                inhibit_cy_q;
    logic                inhibit_ir_q;
    csr_pkg::data_word_t inhibit_word;

    // mcountinhibit, only CY and IR are implemented
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inhibit_cy_q <= 1'b0;
            inhibit_ir_q <= 1'b0;
        end else if (wen_i.inhibit) begin
            inhibit_cy_q <= wdata_i[csr_pkg::INHIBIT_CY_BIT];
            inhibit_ir_q <= wdata_i[csr_pkg::INHIBIT_IR_BIT];
        end
    end

    always_comb begin
        inhibit_word                          = '0;
        inhibit_word[csr_pkg::INHIBIT_CY_BIT] = inhibit_cy_q;
        inhibit_word[csr_pkg::INHIBIT_IR_BIT] = inhibit_ir_q;
    end

    // High words are zero-extended when the counter is narrower than 64
    always_comb begin
        case (sel_i)
            csr_pkg::SEL_MSTATUS:  rdata_o = mstatus_i;
            csr_pkg::SEL_MTVEC:    rdata_o = mtvec_i;
            csr_pkg::SEL_INHIBIT:  rdata_o = inhibit_word;
            csr_pkg::SEL_MSCRATCH: rdata_o = mscratch_i;
            csr_pkg::SEL_MEPC:     rdata_o = mepc_i;
            csr_pkg::SEL_MCAUSE:   rdata_o = mcause_i;
            csr_pkg::SEL_CY_LO:    rdata_o = cycle_i[31:0];
            csr_pkg::SEL_CY_HI:    rdata_o = csr_pkg::data_word_t'(cycle_i[CNT_WIDTH-1:32]);
            csr_pkg::SEL_IR_LO:    rdata_o = instret_i[31:0];
            csr_pkg::SEL_IR_HI:    rdata_o = csr_pkg::data_word_t'(instret_i[CNT_WIDTH-1:32]);
            default:               rdata_o = '0;
        endcase
    end

    assign inhibit_cy_o = inhibit_cy_q;
    assign inhibit_ir_o = inhibit_ir_q;

endmodule : csr_read_mux

`default_nettype wire

// File: rtl/csr_unit.sv
// ======================================================================
// Machine-mode CSR unit
// Top level: address decode, trap state, mcycle/minstret counters and
// the read-data multiplexer
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_unit #(
    parameter int CNT_WIDTH = 64
) (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                csr_access_i,
    input  wire logic                csr_write_i,
    input  wire csr_pkg::csr_addr_t  csr_addr_i,
    input  wire csr_pkg::data_word_t csr_wdata_i,
    input  wire logic                interrupt_request_i,
    input  wire logic [7:0]          interrupt_vector_i,
    input  wire logic                exception_i,
    input  wire logic [4:0]          exception_vector_i,
    input  wire csr_pkg::data_word_t trap_pc_i,
    input  wire logic                mret_i,
    input  wire logic                instr_retired_i,
    output csr_pkg::data_word_t      csr_rdata_o,
    output logic                     illegal_privilege_o,
    output logic                     illegal_instruction_o,
    output logic                     illegal_csr_access_o,
    output csr_pkg::data_word_t      handler_pc_o,
    output csr_pkg::data_word_t      mepc_o,
    output logic                     glb_int_enable_o,
    output csr_pkg::priv_e           current_privilege_o
);

    csr_pkg::csr_sel_e   sel;
    csr_pkg::csr_wen_t   wen;
    csr_pkg::priv_e      privilege;
    csr_pkg::data_word_t mstatus, mtvec, mscratch, mepc, mcause;
    logic [CNT_WIDTH-1:0] cycle, instret;
    logic                inhibit_cy, inhibit_ir;

    // ==================================================================
    // Decode
    // ==================================================================
    csr_addr_decode i_decode (
        .csr_access_i, .csr_write_i, .csr_addr_i,
        .privilege_i (privilege),
        .sel_o       (sel),
        .wen_o       (wen),
        .illegal_privilege_o, .illegal_instruction_o, .illegal_csr_access_o
    );

    // ==================================================================
    // Execute
    // ==================================================================
    csr_trap_state i_trap_state (
        .clk_i, .rst_n_i,
        .wen_i       (wen),
        .wdata_i     (csr_wdata_i),
        .interrupt_request_i, .interrupt_vector_i,
        .exception_i, .exception_vector_i,
        .trap_pc_i, .mret_i,
        .privilege_o (privilege),
        .mstatus_o   (mstatus),
        .mtvec_o     (mtvec),
        .mscratch_o  (mscratch),
        .mepc_o      (mepc),
        .mcause_o    (mcause),
        .handler_pc_o
    );

    // mcycle counts every clock
    csr_counter #(.CNT_WIDTH(CNT_WIDTH)) i_cycle (
        .clk_i, .rst_n_i,
        .inc_i (1'b1), .inhibit_i (inhibit_cy),
        .wr_lo_i (wen.cy_lo), .wr_hi_i (wen.cy_hi),
        .wdata_i (csr_wdata_i), .count_o (cycle)
    );

    csr_counter #(.CNT_WIDTH(CNT_WIDTH)) i_instret (
        .clk_i, .rst_n_i,
        .inc_i (instr_retired_i), .inhibit_i (inhibit_ir),
        .wr_lo_i (wen.ir_lo), .wr_hi_i (wen.ir_hi),
        .wdata_i (csr_wdata_i), .count_o (instret)
    );

    // ==================================================================
    // Result
    // ==================================================================
    csr_read_mux #(.CNT_WIDTH(CNT_WIDTH)) i_read_mux (
        .clk_i, .rst_n_i,
        .sel_i (sel), .wen_i (wen), .wdata_i (csr_wdata_i),
        .mstatus_i (mstatus), .mtvec_i (mtvec), .mscratch_i (mscratch),
        .mepc_i (mepc), .mcause_i (mcause),
        .cycle_i (cycle), .instret_i (instret),
        .rdata_o (csr_rdata_o),
        .inhibit_cy_o (inhibit_cy), .inhibit_ir_o (inhibit_ir)
    );

    assign mepc_o              = mepc;
    assign glb_int_enable_o    = mstatus[csr_pkg::MSTATUS_MIE_BIT];
    assign current_privilege_o = privilege;

endmodule : csr_unit

`default_nettype wire

// File: bench/csr_unit_props.sv
// ======================================================================
// CSR unit assertions
// Concurrent checks on the csr_unit ports, bound into the DUT
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_unit_props (
    input wire logic           clk_i,
    input wire logic           rst_n_i,
    input wire logic           csr_access_i,
    input wire logic           exception_i,
    input wire logic           illegal_privilege_o,
    input wire logic           illegal_instruction_o,
    input wire logic           illegal_csr_access_o,
    input wire logic [31:0]    mepc_o,
    input wire csr_pkg::priv_e current_privilege_o
);

    // Flags only come with an access
    a_flags_need_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !csr_access_i |-> !(illegal_privilege_o || illegal_instruction_o ||
                            illegal_csr_access_o))
        else $error("illegal-access flag raised without csr_access_i");

    // Exceptions always land in machine mode
    a_exception_machine: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exception_i |=> current_privilege_o == csr_pkg::MACHINE)
        else $error("privilege is not MACHINE after an exception");

    a_mepc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mepc_o[0] == 1'b0)
        else $error("mepc bit 0 is set");

endmodule : csr_unit_props

bind csr_unit csr_unit_props i_props (
    .clk_i, .rst_n_i, .csr_access_i, .exception_i,
    .illegal_privilege_o, .illegal_instruction_o, .illegal_csr_access_o,
    .mepc_o, .current_privilege_o
);

`default_nettype wire

// File: bench/csr_unit_tb.sv
// ======================================================================
// CSR unit testbench
// Directed tests for reset, scratch, counters, traps, handler address
// and the privilege and illegal-access checks of csr_unit
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_unit_tb;

    // Whole run stays below 200 cycles, limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    // mstatus after a trap from machine mode: MPIE set, MPP MACHINE
    localparam logic [31:0] MSTATUS_TRAPPED = 32'h0000_1880;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                csr_access;
    logic                csr_write;
    csr_pkg::csr_addr_t  csr_addr;
    logic [31:0]         csr_wdata;
    logic                interrupt_request;
    logic [7:0]          interrupt_vector;
    logic                exception;
    logic [4:0]          exception_vector;
    logic [31:0]         trap_pc;
    logic                mret;
    logic                instr_retired;
    logic [31:0]         csr_rdata;
    logic                illegal_privilege;
    logic                illegal_instruction;
    logic                illegal_csr_access;
    logic [31:0]         handler_pc;
    logic [31:0]         mepc;
    logic                glb_int_enable;
    csr_pkg::priv_e      current_privilege;
    logic [31:0]         lcg_state = 32'd90255;
    int                  cycle_count = 0;

    csr_unit #(.CNT_WIDTH(64)) i_dut (
        .clk_i (clk), .rst_n_i (rst_n),
        .csr_access_i (csr_access), .csr_write_i (csr_write),
        .csr_addr_i (csr_addr), .csr_wdata_i (csr_wdata),
        .interrupt_request_i (interrupt_request), .interrupt_vector_i (interrupt_vector),
        .exception_i (exception), .exception_vector_i (exception_vector),
        .trap_pc_i (trap_pc), .mret_i (mret), .instr_retired_i (instr_retired),
        .csr_rdata_o (csr_rdata),
        .illegal_privilege_o (illegal_privilege),
        .illegal_instruction_o (illegal_instruction),
        .illegal_csr_access_o (illegal_csr_access),
        .handler_pc_o (handler_pc), .mepc_o (mepc),
        .glb_int_enable_o (glb_int_enable), .current_privilege_o (current_privilege)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // ==================================================================
    // Helpers
    // ==================================================================
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Sync reset held over two rising edges
    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // All access tasks start and end just after a falling edge
    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        csr_access = 1'b1;
        csr_write  = 1'b1;
        csr_addr   = addr;
        csr_wdata  = data;
        @(negedge clk);
        csr_access = 1'b0;
        csr_write  = 1'b0;
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
        csr_access = 1'b1;
        csr_write  = 1'b0;
        csr_addr   = addr;
        // Read path is combinational
        #1;
        data = csr_rdata;
        @(negedge clk);
        csr_access = 1'b0;
    endtask

    task automatic expect_csr(input string name, input logic [11:0] addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        read_csr(addr, data);
        check_value(name, data, expected);
    endtask

    task automatic expect_flags(input logic [11:0] addr, input logic wr, input logic [31:0] data,
                                input logic exp_priv, input logic exp_instr,
                                input logic exp_csr);
        csr_access = 1'b1;
        csr_write  = wr;
        csr_addr   = addr;
        csr_wdata  = data;
        #1;
        check_value("illegal_privilege_o", illegal_privilege, exp_priv);
        check_value("illegal_instruction_o", illegal_instruction, exp_instr);
        check_value("illegal_csr_access_o", illegal_csr_access, exp_csr);
        @(negedge clk);
        csr_access = 1'b0;
        csr_write  = 1'b0;
    endtask

    // Trap strobes last one cycle
    task automatic raise_exception(input logic [4:0] vec, input logic [31:0] pc);
        exception        = 1'b1;
        exception_vector = vec;
        trap_pc          = pc;
        @(negedge clk);
        exception = 1'b0;
    endtask

    task automatic raise_interrupt(input logic [7:0] vec, input logic [31:0] pc);
        interrupt_request = 1'b1;
        interrupt_vector  = vec;
        trap_pc           = pc;
        @(negedge clk);
        interrupt_request = 1'b0;
    endtask

    task automatic pulse_mret();
        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
    endtask

    // ==================================================================
    // Directed tests
    // ==================================================================
    task automatic test_reset_scratch();
        logic [31:0] scratch_val;
        logic [31:0] tvec_val;
        check_value("current_privilege_o", current_privilege, csr_pkg::MACHINE);
        check_value("glb_int_enable_o", glb_int_enable, 1'b0);
        scratch_val = next_random();
        tvec_val    = next_random();
        write_csr(12'h340, scratch_val);
        write_csr(12'h305, tvec_val);
        expect_csr("mscratch", 12'h340, scratch_val);
        // mtvec keeps its mode bits
        expect_csr("mtvec", 12'h305, tvec_val);
    endtask

    task automatic test_counters();
        logic [31:0] cy_lo, cy_hi, ir_lo, ir_hi, lo, hi;
        logic [63:0] expected;
        int          n;
        cy_lo = next_random();
        cy_hi = next_random();
        ir_lo = next_random();
        ir_hi = next_random();
        // Freeze both counters first
        write_csr(12'h320, 32'h0000_0005);
        write_csr(12'hB00, cy_lo);
        write_csr(12'hB80, cy_hi);
        write_csr(12'hB02, ir_lo);
        write_csr(12'hB82, ir_hi);
        expect_csr("mcycle", 12'hB00, cy_lo);
        expect_csr("mcycleh", 12'hB80, cy_hi);
        expect_csr("minstret", 12'hB02, ir_lo);
        expect_csr("minstreth", 12'hB82, ir_hi);
        expect_csr("cycle", 12'hC00, cy_lo);
        expect_csr("cycleh", 12'hC80, cy_hi);
        expect_csr("instret", 12'hC02, ir_lo);
        expect_csr("instreth", 12'hC82, ir_hi);
        // Release minstret only and retire n instructions
        write_csr(12'h320, 32'h0000_0001);
        n = 1 + int'(next_random() % 32'd8);
        instr_retired = 1'b1;
        repeat (n) @(negedge clk);
        instr_retired = 1'b0;
        expected = {ir_hi, ir_lo} + 64'(n);
        read_csr(12'hC02, lo);
        read_csr(12'hC82, hi);
        check_value("instret", {hi, lo}, expected);
    endtask

    task automatic test_traps();
        logic [4:0]  ev;
        logic [7:0]  iv;
        logic [31:0] pc;
        write_csr(12'h300, 32'h0000_0008);
        check_value("glb_int_enable_o", glb_int_enable, 1'b1);
        ev = 5'(next_random());
        pc = next_random() & 32'hFFFF_FFFC;
        raise_exception(ev, pc);
        check_value("mepc_o", mepc, pc);
        expect_csr("mcause", 12'h342, {27'b0, ev});
        expect_csr("mstatus", 12'h300, MSTATUS_TRAPPED);
        // Same again with an interrupt
        write_csr(12'h300, 32'h0000_0008);
        iv = 8'(next_random());
        pc = next_random() & 32'hFFFF_FFFC;
        raise_interrupt(iv, pc);
        check_value("mepc_o", mepc, pc);
        expect_csr("mcause", 12'h342, {1'b1, 23'b0, iv});
        expect_csr("mstatus", 12'h300, MSTATUS_TRAPPED);
    endtask

    task automatic test_handler();
        logic [31:0] base;
        logic [7:0]  iv;
        base = next_random() & 32'hFFFF_FFFC;
        iv   = 8'(next_random());
        write_csr(12'h305, base);
        @(negedge clk);
        check_value("handler_pc_o", handler_pc, base);
        // Vectored mode, mode field 1
        write_csr(12'h305, base | 32'h1);
        raise_interrupt(iv, 32'h0000_1000);
        check_value("handler_pc_o", handler_pc, base + {22'b0, iv, 2'b00});
        raise_exception(5'd2, 32'h0000_2000);
        check_value("handler_pc_o", handler_pc, base);
    endtask

    task automatic test_privilege();
        reset_dut();
        // First mret returns to MPP MACHINE and leaves MPP USER
        pulse_mret();
        pulse_mret();
        check_value("current_privilege_o", current_privilege, csr_pkg::USER);
        expect_flags(12'h340, 1'b0, 32'h0, 1'b1, 1'b0, 1'b0);
        expect_flags(12'h340, 1'b1, next_random(), 1'b1, 1'b0, 1'b0);
        expect_flags(12'hC00, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
        expect_flags(12'hC00, 1'b1, 32'h0, 1'b0, 1'b1, 1'b0);
        // 0x7FF also carries machine privilege in its address
        expect_flags(12'h7FF, 1'b0, 32'h0, 1'b1, 1'b0, 1'b1);
        // Back to machine mode, blocked write left mscratch at reset value
        raise_exception(5'd3, 32'h0000_0100);
        check_value("current_privilege_o", current_privilege, csr_pkg::MACHINE);
        expect_csr("mscratch", 12'h340, 32'h0);
    endtask

    // ==================================================================
    // Sequence
    // ==================================================================
    initial begin
        rst_n             = 1'b0;
        csr_access        = 1'b0;
        csr_write         = 1'b0;
        csr_addr          = 12'h000;
        csr_wdata         = 32'h0;
        interrupt_request = 1'b0;
        interrupt_vector  = 8'h0;
        exception         = 1'b0;
        exception_vector  = 5'h0;
        trap_pc           = 32'h0;
        mret              = 1'b0;
        instr_retired     = 1'b0;
        reset_dut();
        test_reset_scratch();
        test_counters();
        test_traps();
        test_handler();
        test_privilege();
        $display("Simulation passed");
        $finish;
    end

endmodule : csr_unit_tb

`default_nettype wire

// File: files.f
rtl/csr_pkg.sv
rtl/csr_addr_decode.sv
rtl/csr_trap_state.sv
rtl/csr_counter.sv
rtl/csr_read_mux.sv
rtl/csr_unit.sv
bench/csr_unit_props.sv
bench/csr_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the CSR unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module csr_unit_tb -Mdir obj_dir

# The simulator exits non-zero on a fatal check, the log decides the verdict
./obj_dir/Vcsr_unit_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    exit 1
fi
exit 0
